// File: logic/ti_mem_pkg.sv
// ======================================================================
// TI-99/4A memory steering package
// bus types, region and sequencer encodings, word-address memory map
// ======================================================================

package ti_mem_pkg;

  // ====================================================================
  // bus types
  // ====================================================================
  typedef logic [22:0] word_addr_t;   // cpu word address
  typedef logic [15:0] data_t;        // high byte in 15:8
  typedef logic [1:0]  byte_en_t;     // bit 1 high lane, bit 0 low lane

  typedef enum logic [1:0] {
    REGION_NONE     = 2'd0,           // unmapped, reads as zero
    REGION_PAD      = 2'd1,           // on-chip scratchpad
    REGION_GROM_EXT = 2'd2,           // on-chip cartridge grom
    REGION_EXT      = 2'd3            // external memory
  } region_e;

  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    ISSUE = 2'd1,                     // delayed strobe cycle
    WAIT  = 2'd2                      // waiting for ack
  } ext_state_e;

  // on-chip ram sizes, in word-address bits
  localparam int PAD_ADDR_BITS  = 9;
  localparam int GROM_ADDR_BITS = 14;

  localparam int EXT_TIMEOUT_DEFAULT = 100;  // wait cycles

  // ====================================================================
  // memory map, word addresses, inclusive bounds
  // ====================================================================
  localparam word_addr_t PAD_FIRST  = 23'h004000;  // scratchpad
  localparam word_addr_t PAD_LAST   = 23'h0041FF;
  localparam word_addr_t GROM_FIRST = 23'h008000;  // whole grom window
  localparam word_addr_t GROM_LAST  = 23'h00FFFF;
  localparam word_addr_t EXPL_FIRST = 23'h001000;  // low 32K expansion
  localparam word_addr_t EXPL_LAST  = 23'h001FFF;
  localparam word_addr_t EXPH_FIRST = 23'h005000;  // high 32K expansion
  localparam word_addr_t EXPH_LAST  = 23'h007FFF;
  localparam word_addr_t DSR_FIRST  = 23'h018000;  // dsr rom
  localparam word_addr_t DSR_LAST   = 23'h01FFFF;
  localparam word_addr_t SAMS_FIRST = 23'h080000;  // sams and cartridges
  localparam word_addr_t SAMS_LAST  = 23'h1FFFFF;

  // grom extension pages, address bits 14:12 inside the grom window
  localparam logic [2:0] GROM_EXT_PAGE_MIN = 3'd3;
  localparam logic [2:0] GROM_EXT_PAGE_MAX = 3'd6;

endpackage

// File: logic/ti_addr_decode.sv
// ======================================================================
// address decoder
// sorts a cpu word address into pad, grom extension, external or none
// ======================================================================
`timescale 1ns/100ps

module ti_addr_decode
(
  input  ti_mem_pkg::word_addr_t i_addr,
  output ti_mem_pkg::region_e    o_region
);

  // ====================================================================
  // window hits
  // ====================================================================
  logic pad_hit;
  logic grom_hit;
  logic grom_ext_hit;
  logic exp_hit;
  logic dsr_hit;
  logic sams_hit;
  logic [2:0] grom_page;     // a14..a12 of the cpu, word bits 14:12

  assign grom_page = i_addr[14:12];

  assign pad_hit  = (i_addr >= ti_mem_pkg::PAD_FIRST)  && (i_addr <= ti_mem_pkg::PAD_LAST);
  assign grom_hit = (i_addr >= ti_mem_pkg::GROM_FIRST) && (i_addr <= ti_mem_pkg::GROM_LAST);

  // pages 3..6 hold cartridge grom, 7 and 0..2 stay console grom
  assign grom_ext_hit = grom_hit
                     && (grom_page >= ti_mem_pkg::GROM_EXT_PAGE_MIN)
                     && (grom_page <= ti_mem_pkg::GROM_EXT_PAGE_MAX);

  // both halves of the 32K expansion
  assign exp_hit = ((i_addr >= ti_mem_pkg::EXPL_FIRST) && (i_addr <= ti_mem_pkg::EXPL_LAST))
                || ((i_addr >= ti_mem_pkg::EXPH_FIRST) && (i_addr <= ti_mem_pkg::EXPH_LAST));

  assign dsr_hit  = (i_addr >= ti_mem_pkg::DSR_FIRST)  && (i_addr <= ti_mem_pkg::DSR_LAST);
  assign sams_hit = (i_addr >= ti_mem_pkg::SAMS_FIRST) && (i_addr <= ti_mem_pkg::SAMS_LAST);

  // ====================================================================
  // region select, grom extension wins over console grom
  // ====================================================================
  always_comb
  begin
    if (pad_hit)
    begin
      o_region = ti_mem_pkg::REGION_PAD;
    end
    else if (grom_ext_hit)
    begin
      o_region = ti_mem_pkg::REGION_GROM_EXT;
    end
    else if (grom_hit || exp_hit || dsr_hit || sams_hit)
    begin
      o_region = ti_mem_pkg::REGION_EXT;       // console grom lands here too
    end
    else
    begin
      o_region = ti_mem_pkg::REGION_NONE;
    end
  end

  // known address must never give an unknown region to the memory paths
  always_comb
  begin
    if (!$isunknown(i_addr))
    begin
      region_known : assert final (!$isunknown(o_region));
    end
  end

endmodule

// File: logic/ti_onchip_mem.sv
// ======================================================================
// on-chip memories
// scratchpad and cartridge grom ram, byte-lane writes, registered reads
// ======================================================================
`timescale 1ns/100ps

module ti_onchip_mem
(
  input  logic                   clk,
  input  logic                   i_rst_n,
  input  logic                   i_as,
  input  logic                   i_we,
  input  ti_mem_pkg::byte_en_t   i_be,
  input  ti_mem_pkg::word_addr_t i_addr,
  input  ti_mem_pkg::data_t      i_wdata,
  input  ti_mem_pkg::region_e    i_region,
  output ti_mem_pkg::data_t      o_rdata
);

  localparam int PAD_WORDS  = 2 ** ti_mem_pkg::PAD_ADDR_BITS;
  localparam int GROM_WORDS = 2 ** ti_mem_pkg::GROM_ADDR_BITS;

  // one array per byte lane
  logic [7:0] pad_lo  [PAD_WORDS];
  logic [7:0] pad_hi  [PAD_WORDS];
  logic [7:0] grom_lo [GROM_WORDS];
  logic [7:0] grom_hi [GROM_WORDS];

  logic [ti_mem_pkg::PAD_ADDR_BITS-1:0]  pad_idx;
  logic [ti_mem_pkg::GROM_ADDR_BITS-1:0] grom_idx;
  logic pad_wr;
  logic grom_wr;
  ti_mem_pkg::data_t pad_rd_q;
  ti_mem_pkg::data_t grom_rd_q;
  logic sel_grom_q;                     // which array the last strobe read

  assign pad_idx  = i_addr[ti_mem_pkg::PAD_ADDR_BITS-1:0];
  assign grom_idx = i_addr[ti_mem_pkg::GROM_ADDR_BITS-1:0];   // pages wrap into 16K

  assign pad_wr  = i_as && i_we && (i_region == ti_mem_pkg::REGION_PAD);
  assign grom_wr = i_as && i_we && (i_region == ti_mem_pkg::REGION_GROM_EXT);

  // ====================================================================
  // arrays, write at the strobe edge
  // ====================================================================
  always_ff @(posedge clk)
  begin
    if (pad_wr && i_be[0]) pad_lo[pad_idx] <= i_wdata[7:0];
    if (pad_wr && i_be[1]) pad_hi[pad_idx] <= i_wdata[15:8];
    if (grom_wr && i_be[0]) grom_lo[grom_idx] <= i_wdata[7:0];
    if (grom_wr && i_be[1]) grom_hi[grom_idx] <= i_wdata[15:8];
    // read ports, old data on a same-cycle write
    pad_rd_q  <= {pad_hi[pad_idx], pad_lo[pad_idx]};
    grom_rd_q <= {grom_hi[grom_idx], grom_lo[grom_idx]};
  end

  // remember the region of the strobe so the word stays put between accesses
  always_ff @(posedge clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
      sel_grom_q <= 1'b0;
    else if (i_as)
      sel_grom_q <= (i_region == ti_mem_pkg::REGION_GROM_EXT);
  end

  assign o_rdata = sel_grom_q ? grom_rd_q : pad_rd_q;

endmodule

// File: logic/ti_ext_access.sv
// ======================================================================
// external memory access sequencer
// delayed strobe, wait until ack, gives up after EXT_TIMEOUT cycles
// ======================================================================
`timescale 1ns/100ps

module ti_ext_access
#(
  parameter int EXT_TIMEOUT = ti_mem_pkg::EXT_TIMEOUT_DEFAULT
)
(
  input  logic                   clk,
  input  logic                   i_rst_n,
  input  logic                   i_as,
  input  logic                   i_we,
  input  ti_mem_pkg::byte_en_t   i_be,
  input  ti_mem_pkg::word_addr_t i_addr,
  input  ti_mem_pkg::data_t      i_wdata,
  input  ti_mem_pkg::region_e    i_region,
  input  logic                   i_ext_ack,
  input  ti_mem_pkg::data_t      i_ext_rdata,
  output logic                   o_ext_req,
  output logic                   o_ext_we,
  output ti_mem_pkg::byte_en_t   o_ext_be,
  output ti_mem_pkg::word_addr_t o_ext_addr,
  output ti_mem_pkg::data_t      o_ext_wdata,
  output logic                   o_busy,
  output logic                   o_done,
  output ti_mem_pkg::data_t      o_rdata,
  output logic                   o_timeout
);

  localparam int TW = $clog2(EXT_TIMEOUT + 1);

  ti_mem_pkg::ext_state_e state_q;
  logic [TW-1:0] timer_q;               // req cycles left
  logic ext_hit;
  logic active;
  logic finish;

  assign ext_hit = i_as && (i_region == ti_mem_pkg::REGION_EXT);
  assign active  = (state_q != ti_mem_pkg::IDLE);
  assign finish  = active && (i_ext_ack || (timer_q == TW'(1)));   // ack or out of time

  assign o_ext_req = active;            // high from ISSUE until the finish
  assign o_busy    = active;

  // ====================================================================
  // fsm, timer and sticky timeout flag
  // ====================================================================
  always_ff @(posedge clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      state_q   <= ti_mem_pkg::IDLE;
      timer_q   <= '0;
      o_done    <= 1'b0;
      o_timeout <= 1'b0;
    end
    else
    begin
      o_done <= 1'b0;
      case (state_q)
        ti_mem_pkg::IDLE:
        begin
          if (ext_hit)
          begin
            state_q <= ti_mem_pkg::ISSUE;   // strobe goes out one cycle late
            timer_q <= TW'(EXT_TIMEOUT);
          end
        end
        ti_mem_pkg::ISSUE, ti_mem_pkg::WAIT:
        begin
          if (finish)
          begin
            state_q <= ti_mem_pkg::IDLE;
            o_done  <= 1'b1;
            if (!i_ext_ack)
              o_timeout <= 1'b1;            // held until reset
          end
          else
          begin
            state_q <= ti_mem_pkg::WAIT;
            timer_q <= timer_q - TW'(1);
          end
        end
        default: state_q <= ti_mem_pkg::IDLE;
      endcase
    end
  end

  // request fields and returned word
  always_ff @(posedge clk)
  begin
    if (ext_hit && !active)
    begin
      o_ext_we    <= i_we;
      o_ext_be    <= i_be;
      o_ext_addr  <= i_addr;
      o_ext_wdata <= i_wdata;
    end
    if (finish)
      o_rdata <= (i_ext_ack && !o_ext_we) ? i_ext_rdata : '0;   // zero on timeout
  end

  // cpu must respect busy, only one external access in flight
  as_not_busy : assert property (@(posedge clk) disable iff (!i_rst_n)
    i_as |-> !o_busy);

  // memory side answers only an open request
  ack_with_req : assert property (@(posedge clk) disable iff (!i_rst_n)
    i_ext_ack |-> o_ext_req);

endmodule

// File: logic/ti_read_select.sv
// ======================================================================
// read select
// returns on-chip, external or zero data on the cpu read bus
// ======================================================================
`timescale 1ns/100ps

module ti_read_select
(
  input  logic                clk,
  input  logic                i_rst_n,
  input  logic                i_as,
  input  ti_mem_pkg::region_e i_region,
  input  ti_mem_pkg::data_t   i_onchip_rdata,
  input  logic                i_ext_done,
  input  ti_mem_pkg::data_t   i_ext_rdata,
  output ti_mem_pkg::data_t   o_cpu_rdata
);

  logic                as_q;            // lines up with on-chip read port
  ti_mem_pkg::region_e region_q;
  ti_mem_pkg::data_t   hold_q;          // last value given to the cpu

  always_ff @(posedge clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      as_q     <= 1'b0;
      region_q <= ti_mem_pkg::REGION_NONE;
      hold_q   <= '0;
    end
    else
    begin
      as_q   <= i_as;
      hold_q <= o_cpu_rdata;
      if (i_as)
        region_q <= i_region;
    end
  end

  // ====================================================================
  // data mux
  // ====================================================================
  always_comb
  begin
    o_cpu_rdata = hold_q;                           // default hold
    if (as_q && ((region_q == ti_mem_pkg::REGION_PAD)
              || (region_q == ti_mem_pkg::REGION_GROM_EXT)))
    begin
      o_cpu_rdata = i_onchip_rdata;
    end
    else if (as_q && (region_q == ti_mem_pkg::REGION_NONE))
    begin
      o_cpu_rdata = '0;                             // unmapped
    end
    else if (i_ext_done)
    begin
      o_cpu_rdata = i_ext_rdata;                    // ext result, zero on timeout
    end
  end

endmodule

// File: logic/ti_mem_map.sv
// ======================================================================
// TI-99/4A memory map top level
// decoder, on-chip rams, external sequencer and read select
// ======================================================================
`timescale 1ns/100ps

module ti_mem_map
#(
  parameter int EXT_TIMEOUT = ti_mem_pkg::EXT_TIMEOUT_DEFAULT
)
(
  input  logic                   clk,
  input  logic                   i_rst_n,
  // cpu side
  input  logic                   i_cpu_as,
  input  ti_mem_pkg::word_addr_t i_cpu_addr,
  input  logic                   i_cpu_we,
  input  ti_mem_pkg::byte_en_t   i_cpu_be,
  input  ti_mem_pkg::data_t      i_cpu_wdata,
  output ti_mem_pkg::data_t      o_cpu_rdata,
  output logic                   o_cpu_busy,
  output logic                   o_ext_timeout,
  // external memory side
  output logic                   o_ext_req,
  output ti_mem_pkg::word_addr_t o_ext_addr,
  output logic                   o_ext_we,
  output ti_mem_pkg::byte_en_t   o_ext_be,
  output ti_mem_pkg::data_t      o_ext_wdata,
  input  logic                   i_ext_ack,
  input  ti_mem_pkg::data_t      i_ext_rdata
);

  ti_mem_pkg::region_e region;
  ti_mem_pkg::data_t   onchip_rdata;
  ti_mem_pkg::data_t   ext_rdata;        // captured ext word
  logic                ext_done;

  ti_addr_decode u_addr_decode
  (
    .i_addr   (i_cpu_addr),
    .o_region (region)
  );

  // ====================================================================
  // memory paths, side by side
  // ====================================================================
  ti_onchip_mem u_onchip_mem
  (
    .clk      (clk),
    .i_rst_n  (i_rst_n),
    .i_as     (i_cpu_as),
    .i_we     (i_cpu_we),
    .i_be     (i_cpu_be),
    .i_addr   (i_cpu_addr),
    .i_wdata  (i_cpu_wdata),
    .i_region (region),
    .o_rdata  (onchip_rdata)
  );

  ti_ext_access #(.EXT_TIMEOUT(EXT_TIMEOUT)) u_ext_access
  (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_as        (i_cpu_as),
    .i_we        (i_cpu_we),
    .i_be        (i_cpu_be),
    .i_addr      (i_cpu_addr),
    .i_wdata     (i_cpu_wdata),
    .i_region    (region),
    .i_ext_ack   (i_ext_ack),
    .i_ext_rdata (i_ext_rdata),
    .o_ext_req   (o_ext_req),
    .o_ext_we    (o_ext_we),
    .o_ext_be    (o_ext_be),
    .o_ext_addr  (o_ext_addr),
    .o_ext_wdata (o_ext_wdata),
    .o_busy      (o_cpu_busy),
    .o_done      (ext_done),
    .o_rdata     (ext_rdata),
    .o_timeout   (o_ext_timeout)
  );

  ti_read_select u_read_select
  (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_as           (i_cpu_as),
    .i_region       (region),
    .i_onchip_rdata (onchip_rdata),
    .i_ext_done     (ext_done),
    .i_ext_rdata    (ext_rdata),
    .o_cpu_rdata    (o_cpu_rdata)
  );

endmodule

// File: tb/ti_ext_mem_model.sv
// ======================================================================
// external memory model
// answers each request after 1 to 8 cycles, silent on the dead range
// ======================================================================
`timescale 1ns/100ps

module ti_ext_mem_model
(
  input  logic                   clk,
  input  logic                   i_req,
  input  logic                   i_we,
  input  ti_mem_pkg::byte_en_t   i_be,
  input  ti_mem_pkg::word_addr_t i_addr,
  input  ti_mem_pkg::data_t      i_wdata,
  output logic                   o_ack,
  output ti_mem_pkg::data_t      o_rdata
);

  localparam ti_mem_pkg::word_addr_t DEAD_FIRST = 23'h080000;  // never acked
  localparam ti_mem_pkg::word_addr_t DEAD_LAST  = 23'h08FFFF;

  ti_mem_pkg::word_addr_t addr_q [$];   // written words only
  ti_mem_pkg::data_t      data_q [$];
  integer                 seed;
  int                     left;         // cycles to ack, 0 when idle
  int                     slot;
  ti_mem_pkg::data_t      word;

  // position of a stored word, -1 when never written
  function automatic int find_word(input ti_mem_pkg::word_addr_t a);
    int idx;
    idx = -1;
    for (int i = 0; i < addr_q.size(); i++)
      if (addr_q[i] == a) idx = i;
    return idx;
  endfunction

  // ====================================================================
  // responder, drives on the falling edge
  // ====================================================================
  initial
  begin
    seed    = 32'h7328;
    left    = 0;
    o_ack   = 1'b0;
    o_rdata = '0;
    forever
    begin
      @(negedge clk);
      if (o_ack)
        o_ack = 1'b0;                                  // one-cycle pulse
      else if (!i_req)
        left = 0;
      else if ((i_addr < DEAD_FIRST) || (i_addr > DEAD_LAST))
      begin
        if (left == 0)
          left = 1 + ($unsigned($random(seed)) % 8);   // new request
        left = left - 1;
        if (left == 0)
        begin
          slot = find_word(i_addr);
          // untouched words give a pattern of the whole address
          word = (slot >= 0) ? data_q[slot] : (i_addr[15:0] ^ {i_addr[22:16], i_addr[22:14]});
          if (i_we)
          begin
            if (i_be[1]) word[15:8] = i_wdata[15:8];
            if (i_be[0]) word[7:0] = i_wdata[7:0];
            if (slot >= 0)
              data_q[slot] = word;
            else
            begin
              addr_q.push_back(i_addr);
              data_q.push_back(word);
            end
          end
          o_rdata = word;
          o_ack   = 1'b1;
        end
      end
    end
  end

endmodule

// File: tb/tb_ti_mem_map.sv
// ======================================================================
// testbench for the memory map top level
// replays cpu accesses from a vector file, external side is a model
// ======================================================================
`timescale 1ns/100ps

module tb_ti_mem_map;

  localparam int EXT_TIMEOUT = 40;
  localparam int MAX_VEC     = 64;

  logic                   clk;
  logic                   i_rst_n;
  logic                   i_cpu_as;
  ti_mem_pkg::word_addr_t i_cpu_addr;
  logic                   i_cpu_we;
  ti_mem_pkg::byte_en_t   i_cpu_be;
  ti_mem_pkg::data_t      i_cpu_wdata;
  ti_mem_pkg::data_t      o_cpu_rdata;
  logic                   o_cpu_busy;
  logic                   o_ext_timeout;
  logic                   o_ext_req;
  ti_mem_pkg::word_addr_t o_ext_addr;
  logic                   o_ext_we;
  ti_mem_pkg::byte_en_t   o_ext_be;
  ti_mem_pkg::data_t      o_ext_wdata;
  logic                   i_ext_ack;
  ti_mem_pkg::data_t      i_ext_rdata;

  // vector store, filled from the data file
  logic        vec_we    [MAX_VEC];
  logic [22:0] vec_addr  [MAX_VEC];
  logic [1:0]  vec_be    [MAX_VEC];
  logic [15:0] vec_wdata [MAX_VEC];
  logic [15:0] vec_exp   [MAX_VEC];
  int          num_vec;
  int          cycle_limit;
  int          cycle_count;
  logic        timeout_seen;          // sticky flag the dut should show

  ti_mem_map #(.EXT_TIMEOUT(EXT_TIMEOUT)) i_ti_mem_map
  (
    .clk (clk), .i_rst_n (i_rst_n),
    .i_cpu_as (i_cpu_as), .i_cpu_addr (i_cpu_addr), .i_cpu_we (i_cpu_we),
    .i_cpu_be (i_cpu_be), .i_cpu_wdata (i_cpu_wdata), .o_cpu_rdata (o_cpu_rdata),
    .o_cpu_busy (o_cpu_busy), .o_ext_timeout (o_ext_timeout),
    .o_ext_req (o_ext_req), .o_ext_addr (o_ext_addr), .o_ext_we (o_ext_we),
    .o_ext_be (o_ext_be), .o_ext_wdata (o_ext_wdata),
    .i_ext_ack (i_ext_ack), .i_ext_rdata (i_ext_rdata)
  );

  ti_ext_mem_model ext_mem
  (
    .clk (clk), .i_req (o_ext_req), .i_we (o_ext_we), .i_be (o_ext_be),
    .i_addr (o_ext_addr), .i_wdata (o_ext_wdata), .o_ack (i_ext_ack), .o_rdata (i_ext_rdata)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;           // 40 ns period
  end

  // watchdog, armed once the vector count is known
  initial
  begin
    cycle_count = 0;
    wait (cycle_limit > 0);
    while (cycle_count < cycle_limit)
    begin
      @(posedge clk);
      cycle_count = cycle_count + 1;
    end
    $display("timeout: the run went past %0d clock cycles", cycle_limit);
    $display("CHECKS FAILED");
    $fatal(1, "watchdog expired");
  end

  // ====================================================================
  // helpers
  // ====================================================================
  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected)
    begin
      $display("CHECK FAILED at %0t ns: %s, got %0h, expected %0h", $time, what, got, expected);
      $display("CHECKS FAILED");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // memory map as seen from the cpu, 1 for the external path
  function automatic logic goes_external(input logic [22:0] a);
    if ((a >= 23'h08000) && (a <= 23'h0FFFF))
      return !((a[14:12] >= 3'd3) && (a[14:12] <= 3'd6));   // console grom pages
    return ((a >= 23'h01000) && (a <= 23'h01FFF)) || ((a >= 23'h05000) && (a <= 23'h07FFF))
        || ((a >= 23'h18000) && (a <= 23'h1FFFF)) || ((a >= 23'h80000) && (a <= 23'h1FFFFF));
  endfunction

  task automatic read_vectors();
    int             fd;
    int             n;
    logic [63:0]    op;
    logic [8*100:1] rest;
    fd = $fopen("tb/ti_mem_input.txt", "r");
    if (fd == 0)
    begin
      $display("could not open the vector file tb/ti_mem_input.txt");
      $display("CHECKS FAILED");
      $fatal(1, "no stimulus");
    end
    num_vec = 0;
    while ($fscanf(fd, "%s", op) == 1)
    begin
      if (op == "#")
        n = $fgets(rest, fd);                                // legend line
      else
      begin
        n = $fscanf(fd, "%h %h %h %h", vec_addr[num_vec], vec_be[num_vec],
                    vec_wdata[num_vec], vec_exp[num_vec]);
        if ((n != 4) || (num_vec >= MAX_VEC - 1) || ((op != "write") && (op != "read")))
        begin
          $display("vector line %0d of the input file is malformed", num_vec + 1);
          $display("CHECKS FAILED");
          $fatal(1, "bad vector file");
        end
        vec_we[num_vec] = (op == "write");
        num_vec = num_vec + 1;
      end
    end
    $fclose(fd);
  endtask

  // one cpu access, starting and ending on a falling edge
  task automatic run_access(input int i);
    int   cycles;
    logic saw_req;
    logic saw_busy;
    logic ext;
    ext = goes_external(vec_addr[i]);
    while (o_cpu_busy) @(negedge clk);
    i_cpu_as    = 1'b1;
    i_cpu_we    = vec_we[i];
    i_cpu_addr  = vec_addr[i];
    i_cpu_be    = vec_be[i];
    i_cpu_wdata = vec_wdata[i];
    @(negedge clk);
    i_cpu_as = 1'b0;
    cycles   = 1;
    saw_req  = o_ext_req;              // delayed strobe shows here
    saw_busy = o_cpu_busy;
    while (o_cpu_busy)
    begin
      @(negedge clk);
      cycles = cycles + 1;
    end
    check_value($sformatf("o_ext_req for %h", vec_addr[i]), saw_req, ext);
    check_value($sformatf("o_cpu_busy for %h", vec_addr[i]), saw_busy, ext);
    if (ext)
    begin
      // request fields stay registered from the strobe
      check_value($sformatf("o_ext_addr for %h", vec_addr[i]), o_ext_addr, vec_addr[i]);
      check_value($sformatf("o_ext_we for %h", vec_addr[i]), o_ext_we, vec_we[i]);
      check_value($sformatf("o_ext_be for %h", vec_addr[i]), o_ext_be, vec_be[i]);
      check_value($sformatf("o_ext_wdata for %h", vec_addr[i]), o_ext_wdata, vec_wdata[i]);
    end
    if ((vec_addr[i] >= 23'h80000) && (vec_addr[i] <= 23'h8FFFF))
    begin
      timeout_seen = 1'b1;             // dead range, no ack ever
      check_value("busy ends in time", cycles <= EXT_TIMEOUT + 2, 1);
    end
    check_value($sformatf("o_ext_timeout after %h", vec_addr[i]), o_ext_timeout, timeout_seen);
    if (!vec_we[i])
      check_value($sformatf("read data at %h", vec_addr[i]), o_cpu_rdata, vec_exp[i]);
  endtask

  // ====================================================================
  // main sequence
  // ====================================================================
  initial
  begin
    i_rst_n      = 1'b0;
    i_cpu_as     = 1'b0;
    i_cpu_addr   = '0;
    i_cpu_we     = 1'b0;
    i_cpu_be     = '0;
    i_cpu_wdata  = '0;
    timeout_seen = 1'b0;
    cycle_limit  = 0;
    read_vectors();
    cycle_limit = num_vec * (EXT_TIMEOUT + 12) + 20;
    repeat (2) @(negedge clk);         // two cycles in reset
    i_rst_n = 1'b1;
    check_value("o_ext_req after reset", o_ext_req, 0);
    check_value("o_cpu_busy after reset", o_cpu_busy, 0);
    check_value("o_ext_timeout after reset", o_ext_timeout, 0);
    check_value("o_cpu_rdata after reset", o_cpu_rdata, 0);
    for (int i = 0; i < num_vec; i++)
      run_access(i);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// File: tb/ti_mem_input.txt
# op addr be wdata expect, all values in hex, addr is a word address
# write lines carry 0000 as expect, read lines carry 0000 as wdata
write 004010 3 BEEF 0000
read  004010 0 0000 BEEF
write 0041FF 3 1234 0000
read  0041FF 0 0000 1234
write 004010 1 0055 0000
read  004010 0 0000 BE55
write 004010 2 A700 0000
read  004010 0 0000 A755
write 00B000 3 C0DE 0000
read  00B000 0 0000 C0DE
write 00B000 2 1100 0000
read  00B000 0 0000 11DE
write 001000 3 1357 0000
read  001000 0 0000 1357
write 007FFF 3 2468 0000
write 007FFF 1 00FF 0000
read  007FFF 0 0000 24FF
write 009000 3 9ABC 0000
read  009000 0 0000 9ABC
read  008010 0 0000 8012
write 018000 3 D5D5 0000
read  018000 0 0000 D5D5
write 1FFFFF 3 7E7E 0000
read  1FFFFF 0 0000 7E7E
read  000000 0 0000 0000
read  020000 0 0000 0000
read  080000 0 0000 0000
read  004010 0 0000 A755
read  001000 0 0000 1357

// File: ti_mem_map.f
logic/ti_mem_pkg.sv
logic/ti_addr_decode.sv
logic/ti_onchip_mem.sv
logic/ti_ext_access.sv
logic/ti_read_select.sv
logic/ti_mem_map.sv
tb/ti_ext_mem_model.sv
tb/tb_ti_mem_map.sv
